/* Makefile */
# Verilator build and run of the load queue testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_lq
RTL_TOP   ?= lsu_lq
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* lq_entry.sv */
// One load queue slot. The parent must only allocate an empty slot, replay a
// replayable one and update a launched one; other strobes are ignored here.
// The misspec flag only covers stores that retired before the retire cycle.

`timescale 1ns/100ps
`default_nettype none

module lq_entry (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_flush,

    // Allocation from the reservation station
    input  logic                   i_alloc_en,
    input  lsu_lq_pkg::lq_load_t   i_alloc,

    // Replay select and the stored load
    input  logic                   i_replay_en,
    output lsu_lq_pkg::lq_load_t   o_load,

    // Result of the cache access
    input  logic                   i_update_en,
    input  lsu_lq_pkg::lq_update_t i_update,

    // Miss fill broadcast
    input  logic                   i_fill_en,
    input  lsu_lq_pkg::mhq_tag_t   i_fill_tag,

    // Retiring store, range already computed by the parent
    input  logic                   i_sq_retire_en,
    input  lsu_lq_pkg::lq_store_t  i_store,

    // Retiring load from the ROB
    input  logic                   i_rob_retire_en,
    input  lsu_lq_pkg::rob_tag_t   i_rob_retire_tag,

    output logic                   o_empty,
    output logic                   o_replayable,
    output logic                   o_retire_hit,
    output logic                   o_misspec
);
    import lsu_lq_pkg::*;

    lq_state_t state_q;
    lq_state_t state_d;
    lq_load_t  load_q;
    mhq_tag_t  mhq_tag_q;
    logic      misspec_q;

    lq_addr_t  load_end;
    logic      store_overlap;
    logic      executed;
    logic      fill_match;
    logic      alloc_take;

    assign alloc_take = i_alloc_en && (state_q == LQ_EMPTY);

    // Byte range of the held load, end exclusive
    assign load_end = load_q.addr + lsu_op_size(load_q.op);

    // Two ranges overlap when each starts below the other's end
    assign store_overlap = (load_q.addr < i_store.addr_end) && (i_store.addr < load_end);

    // Only a load that has read the cache can have read stale data
    assign executed = (state_q == LQ_LAUNCHED) || (state_q == LQ_DONE);

    assign fill_match = i_fill_en && (i_fill_tag == mhq_tag_q);

    assign o_retire_hit = i_rob_retire_en && (state_q != LQ_EMPTY) &&
                          (load_q.tag == i_rob_retire_tag);

    assign o_empty      = (state_q == LQ_EMPTY);
    assign o_replayable = (state_q == LQ_REPLAYABLE);
    assign o_load       = load_q;
    assign o_misspec    = misspec_q;

    always_comb begin
        state_d = state_q;

        case (state_q)
            LQ_EMPTY: begin
                if (i_alloc_en) begin
                    state_d = LQ_LAUNCHED;
                end
            end
            LQ_LAUNCHED: begin
                if (i_update_en) begin
                    if (!i_update.retry) begin
                        state_d = LQ_DONE;
                    end else if (i_update.replay || i_update.fill_now) begin
                        state_d = LQ_REPLAYABLE;
                    end else begin
                        state_d = LQ_WAIT_FILL;
                    end
                end
            end
            LQ_WAIT_FILL: begin
                if (fill_match) begin
                    state_d = LQ_REPLAYABLE;
                end
            end
            LQ_REPLAYABLE: begin
                if (i_replay_en) begin
                    state_d = LQ_LAUNCHED;
                end
            end
            LQ_DONE: begin
                state_d = LQ_DONE;
            end
            default: begin
                state_d = LQ_EMPTY;
            end
        endcase

        // Retirement frees the slot whatever it was waiting on
        if (o_retire_hit) begin
            state_d = LQ_EMPTY;
        end

        if (i_flush) begin
            state_d = LQ_EMPTY;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= LQ_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_take) begin
            load_q <= i_alloc;
        end

        // Only the wait state reads the tag, so any update may write it
        if (i_update_en && (state_q == LQ_LAUNCHED)) begin
            mhq_tag_q <= i_update.mhq_tag;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            misspec_q <= 1'b0;
        end else if (alloc_take) begin
            misspec_q <= 1'b0;
        end else if (i_sq_retire_en && executed && store_overlap) begin
            misspec_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* lq_picker.sv */
// Fixed priority picker, the lowest set request bit wins.
// With no request the pick is zero and the index reads as 0.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_lq_config.svh"

module lq_picker (
    input  lsu_lq_pkg::lq_vec_t i_req,
    output lsu_lq_pkg::lq_vec_t o_pick,
    output lsu_lq_pkg::lq_idx_t o_idx,
    output logic                o_any
);
    import lsu_lq_pkg::*;

    // Two's complement trick isolates the lowest set bit
    assign o_pick = i_req & (~i_req + lq_vec_t'(1));

    assign o_any = |i_req;

    // One-hot to binary, OR of the indices of the set bits
    always_comb begin
        o_idx = '0;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            if (o_pick[i]) begin
                o_idx = o_idx | lq_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* lsu_lq.sv */
// Load queue of the load/store unit. The environment must not allocate while
// o_full is high, and ROB tags held in the queue must be unique.
// A retire in the same cycle as a flush is dropped without an ack.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_lq_config.svh"

module lsu_lq (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_flush,
    output logic                   o_full,

    // Allocation of a newly issued load
    input  logic                   i_alloc_en,
    input  lsu_lq_pkg::lq_load_t   i_alloc,
    output lsu_lq_pkg::lq_vec_t    o_alloc_select,

    // Replay of a load back into the execute pipe
    input  logic                   i_replay_stall,
    output logic                   o_replay_en,
    output lsu_lq_pkg::lq_vec_t    o_replay_select,
    output lsu_lq_pkg::lq_load_t   o_replay,

    // Result of a load's cache access
    input  logic                   i_update_en,
    input  lsu_lq_pkg::lq_vec_t    i_update_select,
    input  lsu_lq_pkg::lq_update_t i_update,

    // Miss fill broadcast
    input  logic                   i_fill_en,
    input  lsu_lq_pkg::mhq_tag_t   i_fill_tag,

    // Store retiring from the store queue
    input  logic                   i_sq_retire_en,
    input  lsu_lq_pkg::lsu_op_t    i_sq_retire_op,
    input  lsu_lq_pkg::lq_addr_t   i_sq_retire_addr,

    // Load retiring from the ROB
    input  logic                   i_rob_retire_en,
    input  lsu_lq_pkg::rob_tag_t   i_rob_retire_tag,
    output logic                   o_rob_retire_ack,
    output logic                   o_rob_retire_misspec
);
    import lsu_lq_pkg::*;

    lq_store_t store;

    lq_vec_t   entry_empty;
    lq_vec_t   entry_replayable;
    lq_vec_t   entry_retire_hit;
    lq_vec_t   entry_misspec;
    lq_load_t  entry_load [`LQ_DEPTH];

    lq_vec_t   alloc_pick;
    lq_vec_t   alloc_select;
    lq_vec_t   update_select;

    lq_vec_t   replay_pick;
    lq_idx_t   replay_idx;
    logic      replay_any;
    lq_vec_t   replay_select;
    logic      replay_go;

    // Store range is computed once and broadcast to every slot
    assign store.addr     = i_sq_retire_addr;
    assign store.addr_end = i_sq_retire_addr + lsu_op_size(i_sq_retire_op);

    assign update_select = {`LQ_DEPTH{i_update_en}} & i_update_select;

    for (genvar i = 0; i < `LQ_DEPTH; i++) begin : g_entry
        lq_entry lq_entry_i (
            .clk              (clk),
            .i_rst_n          (i_rst_n),
            .i_flush          (i_flush),
            .i_alloc_en       (alloc_select[i]),
            .i_alloc          (i_alloc),
            .i_replay_en      (replay_select[i]),
            .o_load           (entry_load[i]),
            .i_update_en      (update_select[i]),
            .i_update         (i_update),
            .i_fill_en        (i_fill_en),
            .i_fill_tag       (i_fill_tag),
            .i_sq_retire_en   (i_sq_retire_en),
            .i_store          (store),
            .i_rob_retire_en  (i_rob_retire_en),
            .i_rob_retire_tag (i_rob_retire_tag),
            .o_empty          (entry_empty[i]),
            .o_replayable     (entry_replayable[i]),
            .o_retire_hit     (entry_retire_hit[i]),
            .o_misspec        (entry_misspec[i])
        );
    end

    // Lowest empty slot takes the next load
    lq_picker alloc_picker_i (
        .i_req  (entry_empty),
        .o_pick (alloc_pick),
        .o_idx  (),
        .o_any  ()
    );

    assign alloc_select = {`LQ_DEPTH{i_alloc_en && !i_flush}} & alloc_pick;

    // Full next cycle when the slot taken now was the last empty one
    assign o_full = ((entry_empty & ~alloc_select) == '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_alloc_select <= '0;
        end else begin
            o_alloc_select <= alloc_select;
        end
    end

    // Lowest replayable slot goes back to execute unless the pipe stalls
    lq_picker replay_picker_i (
        .i_req  (entry_replayable),
        .o_pick (replay_pick),
        .o_idx  (replay_idx),
        .o_any  (replay_any)
    );

    assign replay_go     = !i_replay_stall;
    assign replay_select = {`LQ_DEPTH{replay_go}} & replay_pick;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_replay_en <= 1'b0;
        end else if (i_flush) begin
            o_replay_en <= 1'b0;
        end else if (replay_go) begin
            o_replay_en <= replay_any;
        end
    end

    // Payload holds with the enable while the stall is high
    always_ff @(posedge clk) begin
        if (replay_go) begin
            o_replay_select <= replay_select;
            o_replay        <= entry_load[replay_idx];
        end
    end

    // At most one slot matches the retiring tag
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rob_retire_ack <= 1'b0;
        end else begin
            o_rob_retire_ack <= !i_flush && (entry_retire_hit != '0);
        end
    end

    always_ff @(posedge clk) begin
        o_rob_retire_misspec <= |(entry_retire_hit & entry_misspec);
    end

endmodule

`default_nettype wire

/* lsu_lq_config.svh */
// Parameters of the load queue. The depth must be a power of two of at least 2
// for the binary index width to cover every slot exactly.
// Address ranges are compared unsigned, so a range that wraps past zero never overlaps.

`ifndef LSU_LQ_CONFIG_SVH
`define LSU_LQ_CONFIG_SVH

// Number of load queue entries
`define LQ_DEPTH 8

// Byte address width
`define LQ_ADDR_WIDTH 32

// Tag widths of the reorder buffer and the miss handling queue
`define LQ_ROB_IDX_WIDTH 5
`define LQ_MHQ_IDX_WIDTH 2

// Binary entry index, derived from the depth
`define LQ_IDX_WIDTH ((`LQ_DEPTH == 1) ? 1 : $clog2(`LQ_DEPTH))

`endif

/* lsu_lq_pkg.sv */
// Shared types of the load queue. Widths come from the config header.
// Ops outside the known load and store encodings are sized as 4 bytes.

`default_nettype none

`include "lsu_lq_config.svh"

package lsu_lq_pkg;

    typedef logic [`LQ_ADDR_WIDTH-1:0]    lq_addr_t;
    typedef logic [`LQ_ROB_IDX_WIDTH-1:0] rob_tag_t;
    typedef logic [`LQ_MHQ_IDX_WIDTH-1:0] mhq_tag_t;
    typedef logic [`LQ_DEPTH-1:0]         lq_vec_t;
    typedef logic [`LQ_IDX_WIDTH-1:0]     lq_idx_t;

    typedef enum logic [3:0] {
        LB  = 4'd0,
        LH  = 4'd1,
        LW  = 4'd2,
        LBU = 4'd3,
        LHU = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7
    } lsu_op_t;

    // Life of one slot, from allocation until the ROB retires it
    typedef enum logic [2:0] {
        LQ_EMPTY      = 3'd0,
        LQ_LAUNCHED   = 3'd1,
        LQ_WAIT_FILL  = 3'd2,
        LQ_REPLAYABLE = 3'd3,
        LQ_DONE       = 3'd4
    } lq_state_t;

    typedef struct packed {
        lsu_op_t  op;
        rob_tag_t tag;
        lq_addr_t addr;
    } lq_load_t;

    // Result of a load's cache access, sent back by the execute stage
    typedef struct packed {
        logic     retry;
        logic     replay;
        mhq_tag_t mhq_tag;
        logic     fill_now;
    } lq_update_t;

    // Byte range of a retiring store, end exclusive
    typedef struct packed {
        lq_addr_t addr;
        lq_addr_t addr_end;
    } lq_store_t;

    // Access size in bytes of a load or store op
    function automatic lq_addr_t lsu_op_size(input lsu_op_t op);
        case (op)
            LB, LBU, SB: lsu_op_size = lq_addr_t'(1);
            LH, LHU, SH: lsu_op_size = lq_addr_t'(2);
            default:     lsu_op_size = lq_addr_t'(4);
        endcase
    endfunction

endpackage

`default_nettype wire

/* tb_clk_gen.sv */
// Free running clock and active low reset for the testbench.
// Reset is released on a falling edge so that it never races a rising edge.

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            o_clk = ~o_clk;
        end
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_lsu_lq.sv */
// Testbench of the load queue. A cycle model of the queue runs beside the DUT and
// concurrent assertions compare the outputs with it on every rising edge.
// Inputs change on falling edges only. Addresses stay in a small window so that
// random load and store ranges overlap often.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_lq_config.svh"

module tb_lsu_lq;
    import lsu_lq_pkg::*;

    localparam int N               = `LQ_DEPTH;
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 5;
    localparam int REPLAY_TIMEOUT  = 10;
    // Cycle budgets of the five tests, then reset and a margin
    localparam int TEST_CYCLES     = 20 + 30 + 30 + 120 + 20;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + RESET_CYCLES + 100;

    logic       clk;
    logic       rst_n;
    logic       i_flush;
    logic       o_full;
    logic       i_alloc_en;
    lq_load_t   i_alloc;
    lq_vec_t    o_alloc_select;
    logic       i_replay_stall;
    logic       o_replay_en;
    lq_vec_t    o_replay_select;
    lq_load_t   o_replay;
    logic       i_update_en;
    lq_vec_t    i_update_select;
    lq_update_t i_update;
    logic       i_fill_en;
    mhq_tag_t   i_fill_tag;
    logic       i_sq_retire_en;
    lsu_op_t    i_sq_retire_op;
    lq_addr_t   i_sq_retire_addr;
    logic       i_rob_retire_en;
    rob_tag_t   i_rob_retire_tag;
    logic       o_rob_retire_ack;
    logic       o_rob_retire_misspec;

    // Reference model of the slots and of the registered outputs
    lq_state_t  m_state [N];
    lq_load_t   m_load [N];
    mhq_tag_t   m_mhq [N];
    lq_vec_t    m_misspec;
    lq_vec_t    m_empty;
    lq_vec_t    m_replayable;
    lq_vec_t    m_hit;
    lq_vec_t    m_overlap;
    lq_vec_t    m_alloc_sel;
    lq_vec_t    m_replay_sel;
    lq_addr_t   store_end;
    lq_vec_t    exp_alloc_select;
    logic       exp_full;
    logic       exp_replay_en;
    lq_vec_t    exp_replay_select;
    lq_load_t   exp_replay;
    logic       exp_ack;
    logic       exp_misspec;

    integer     seed;
    int         errors;
    int         err_mark;
    int         tests_passed;
    int         tests_failed;
    rob_tag_t   next_tag;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    lsu_lq lsu_lq_i (
        .clk                  (clk),
        .i_rst_n              (rst_n),
        .i_flush              (i_flush),
        .o_full               (o_full),
        .i_alloc_en           (i_alloc_en),
        .i_alloc              (i_alloc),
        .o_alloc_select       (o_alloc_select),
        .i_replay_stall       (i_replay_stall),
        .o_replay_en          (o_replay_en),
        .o_replay_select      (o_replay_select),
        .o_replay             (o_replay),
        .i_update_en          (i_update_en),
        .i_update_select      (i_update_select),
        .i_update             (i_update),
        .i_fill_en            (i_fill_en),
        .i_fill_tag           (i_fill_tag),
        .i_sq_retire_en       (i_sq_retire_en),
        .i_sq_retire_op       (i_sq_retire_op),
        .i_sq_retire_addr     (i_sq_retire_addr),
        .i_rob_retire_en      (i_rob_retire_en),
        .i_rob_retire_tag     (i_rob_retire_tag),
        .o_rob_retire_ack     (o_rob_retire_ack),
        .o_rob_retire_misspec (o_rob_retire_misspec)
    );

    // Access size in bytes, unknown ops count as a word
    function automatic lq_addr_t access_bytes(input lsu_op_t op);
        case (op)
            LB, LBU, SB: access_bytes = lq_addr_t'(1);
            LH, LHU, SH: access_bytes = lq_addr_t'(2);
            default:     access_bytes = lq_addr_t'(4);
        endcase
    endfunction

    function automatic lq_vec_t one_hot(input int slot);
        one_hot = lq_vec_t'(1) << slot;
    endfunction

    function automatic lq_vec_t lowest_bit(input lq_vec_t v);
        lowest_bit = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (v[i]) begin
                lowest_bit = one_hot(i);
            end
        end
    endfunction

    always_comb begin
        lq_addr_t load_end;
        store_end = i_sq_retire_addr + access_bytes(i_sq_retire_op);
        for (int i = 0; i < N; i++) begin
            load_end        = m_load[i].addr + access_bytes(m_load[i].op);
            m_empty[i]      = (m_state[i] == LQ_EMPTY);
            m_replayable[i] = (m_state[i] == LQ_REPLAYABLE);
            m_hit[i]        = i_rob_retire_en && !m_empty[i] &&
                              (m_load[i].tag == i_rob_retire_tag);
            m_overlap[i]    = (m_load[i].addr < store_end) && (i_sq_retire_addr < load_end);
        end
        m_alloc_sel  = (i_alloc_en && !i_flush) ? lowest_bit(m_empty) : '0;
        m_replay_sel = i_replay_stall ? '0 : lowest_bit(m_replayable);
        // Full means no empty slot is left once this cycle's allocation lands
        exp_full     = ($countones(m_empty) == $countones(m_alloc_sel));
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N; i++) begin
                m_state[i] <= LQ_EMPTY;
            end
            m_misspec         <= '0;
            exp_alloc_select  <= '0;
            exp_replay_en     <= 1'b0;
            exp_replay_select <= '0;
            exp_replay        <= '0;
            exp_ack           <= 1'b0;
            exp_misspec       <= 1'b0;
        end else begin
            exp_alloc_select <= m_alloc_sel;
            if (i_flush) begin
                exp_replay_en <= 1'b0;
            end else if (!i_replay_stall) begin
                exp_replay_en <= (m_replayable != '0);
            end
            if (!i_replay_stall) begin
                exp_replay_select <= m_replay_sel;
                for (int i = 0; i < N; i++) begin
                    if (m_replay_sel[i]) begin
                        exp_replay <= m_load[i];
                    end
                end
            end
            exp_ack     <= !i_flush && (m_hit != '0);
            exp_misspec <= |(m_hit & m_misspec);

            for (int i = 0; i < N; i++) begin
                if (i_flush || m_hit[i]) begin
                    m_state[i] <= LQ_EMPTY;
                end else if (m_alloc_sel[i]) begin
                    m_state[i] <= LQ_LAUNCHED;
                    m_load[i]  <= i_alloc;
                end else if (m_state[i] == LQ_LAUNCHED && i_update_en && i_update_select[i]) begin
                    m_mhq[i] <= i_update.mhq_tag;
                    if (!i_update.retry) begin
                        m_state[i] <= LQ_DONE;
                    end else if (i_update.replay || i_update.fill_now) begin
                        m_state[i] <= LQ_REPLAYABLE;
                    end else begin
                        m_state[i] <= LQ_WAIT_FILL;
                    end
                end else if (m_state[i] == LQ_WAIT_FILL && i_fill_en && i_fill_tag == m_mhq[i]) begin
                    m_state[i] <= LQ_REPLAYABLE;
                end else if (m_replay_sel[i]) begin
                    m_state[i] <= LQ_LAUNCHED;
                end

                // Only a load that already read the cache can be hit by a store
                if (m_alloc_sel[i]) begin
                    m_misspec[i] <= 1'b0;
                end else if (i_sq_retire_en && m_overlap[i] &&
                             (m_state[i] == LQ_LAUNCHED || m_state[i] == LQ_DONE)) begin
                    m_misspec[i] <= 1'b1;
                end
            end
        end
    end

    task automatic value_error(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        $display("[ERROR] %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        errors++;
    endtask

    alloc_select_check: assert property (@(posedge clk) disable iff (!rst_n)
        o_alloc_select == exp_alloc_select)
        else value_error("o_alloc_select", $sampled(exp_alloc_select), $sampled(o_alloc_select));

    full_check: assert property (@(posedge clk) disable iff (!rst_n) o_full == exp_full)
        else value_error("o_full", $sampled(exp_full), $sampled(o_full));

    replay_en_check: assert property (@(posedge clk) disable iff (!rst_n)
        o_replay_en == exp_replay_en)
        else value_error("o_replay_en", $sampled(exp_replay_en), $sampled(o_replay_en));

    replay_select_check: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_replay_en || o_replay_select == exp_replay_select)
        else value_error("o_replay_select", $sampled(exp_replay_select),
                         $sampled(o_replay_select));

    replay_load_check: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_replay_en || o_replay == exp_replay)
        else value_error("o_replay", $sampled(exp_replay), $sampled(o_replay));

    retire_ack_check: assert property (@(posedge clk) disable iff (!rst_n)
        o_rob_retire_ack == exp_ack)
        else value_error("o_rob_retire_ack", $sampled(exp_ack), $sampled(o_rob_retire_ack));

    retire_misspec_check: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_ack || o_rob_retire_misspec == exp_misspec)
        else value_error("o_rob_retire_misspec", $sampled(exp_misspec),
                         $sampled(o_rob_retire_misspec));

    task automatic clear_strobes();
        i_flush         = 1'b0;
        i_alloc_en      = 1'b0;
        i_update_en     = 1'b0;
        i_fill_en       = 1'b0;
        i_sq_retire_en  = 1'b0;
        i_rob_retire_en = 1'b0;
    endtask

    function automatic lq_addr_t random_addr();
        random_addr = lq_addr_t'(32'h0000_1000 + {$random(seed)} % 48);
    endfunction

    function automatic lsu_op_t random_op(input logic store);
        logic [3:0] code;
        code = store ? 4'(5 + {$random(seed)} % 3) : 4'({$random(seed)} % 5);
        random_op = lsu_op_t'(code);
    endfunction

    task automatic alloc_load(input lsu_op_t op, input lq_addr_t addr);
        @(negedge clk);
        clear_strobes();
        i_alloc_en   = 1'b1;
        i_alloc.op   = op;
        i_alloc.tag  = next_tag;
        i_alloc.addr = addr;
        next_tag     = next_tag + 1'b1;
    endtask

    task automatic update_slot(input int slot, input logic retry, input logic replay,
                               input mhq_tag_t tag, input logic fill_now);
        @(negedge clk);
        clear_strobes();
        i_update_en       = 1'b1;
        i_update_select   = one_hot(slot);
        i_update.retry    = retry;
        i_update.replay   = replay;
        i_update.mhq_tag  = tag;
        i_update.fill_now = fill_now;
    endtask

    task automatic fill(input mhq_tag_t tag);
        @(negedge clk);
        clear_strobes();
        i_fill_en  = 1'b1;
        i_fill_tag = tag;
    endtask

    task automatic retire_store(input lsu_op_t op, input lq_addr_t addr);
        @(negedge clk);
        clear_strobes();
        i_sq_retire_en   = 1'b1;
        i_sq_retire_op   = op;
        i_sq_retire_addr = addr;
    endtask

    // The ack must follow exactly one cycle after the retire strobe
    task automatic retire_load(input rob_tag_t tag);
        @(negedge clk);
        clear_strobes();
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag;
        @(negedge clk);
        clear_strobes();
        assert (o_rob_retire_ack)
            else note_failure($sformatf("no retire ack one cycle after ROB tag %0d", tag));
    endtask

    task automatic wait_replay(input int slot);
        int cycles;
        cycles = 0;
        @(negedge clk);
        clear_strobes();
        while (!o_replay_en && cycles < REPLAY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_replay_en) begin
            note_failure($sformatf("slot %0d did not replay within %0d cycles",
                                   slot, REPLAY_TIMEOUT));
        end else begin
            assert (o_replay_select == one_hot(slot))
                else value_error("o_replay_select", one_hot(slot), o_replay_select);
        end
    endtask

    task automatic check_no_replay(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            clear_strobes();
            assert (!o_replay_en) else value_error("o_replay_en", 0, o_replay_en);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == err_mark) begin
            tests_passed++;
            $display("Test %0d (%s) passed", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d (%s) failed with %0d errors", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        seed             = 35397;
        errors           = 0;
        err_mark         = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        next_tag         = '0;
        i_replay_stall   = 1'b1;
        i_alloc          = '0;
        i_update_select  = '0;
        i_update         = '0;
        i_fill_tag       = '0;
        i_sq_retire_op   = SB;
        i_sq_retire_addr = '0;
        i_rob_retire_tag = '0;
        clear_strobes();
        wait (rst_n === 1'b1);

        // Fill every slot while replays are held back
        for (int i = 0; i < N; i++) begin
            alloc_load(random_op(1'b0), random_addr());
        end
        @(negedge clk);
        clear_strobes();
        assert (o_full) else value_error("o_full", 1, o_full);
        finish_test(1, "allocation and full");

        update_slot(4, 1'b1, 1'b1, '0, 1'b0);
        update_slot(1, 1'b1, 1'b1, '0, 1'b0);
        check_no_replay(3);
        i_replay_stall = 1'b0;
        wait_replay(1);
        // Stall again with slot 4 still waiting, the outputs must hold slot 1
        i_replay_stall = 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (o_replay_en && o_replay_select == one_hot(1))
                else value_error("o_replay_select", one_hot(1), o_replay_select);
        end
        i_replay_stall = 1'b0;
        wait_replay(4);
        finish_test(2, "replay and stall");

        update_slot(6, 1'b1, 1'b0, 2'd2, 1'b0);
        fill(2'd0);
        fill(2'd1);
        fill(2'd3);
        check_no_replay(3);
        fill(2'd2);
        wait_replay(6);
        update_slot(7, 1'b1, 1'b0, 2'd0, 1'b1);
        wait_replay(7);
        finish_test(3, "miss wake-up");

        // First round retires completed loads, the second round launched ones
        for (int round = 0; round < 2; round++) begin
            if (round == 0) begin
                for (int i = 0; i < N; i++) begin
                    update_slot(i, 1'b0, 1'b0, '0, 1'b0);
                end
            end
            for (int s = 0; s < 6; s++) begin
                retire_store(random_op(1'b1), random_addr());
            end
            for (int i = 0; i < N; i++) begin
                retire_load(m_load[i].tag);
                alloc_load(random_op(1'b0), random_addr());
                @(negedge clk);
                clear_strobes();
                assert (o_alloc_select == one_hot(i))
                    else value_error("o_alloc_select", one_hot(i), o_alloc_select);
            end
        end
        finish_test(4, "mis-speculation on retire");

        i_replay_stall = 1'b1;
        update_slot(0, 1'b1, 1'b1, '0, 1'b0);
        @(negedge clk);
        clear_strobes();
        // The flush meets a replay pick of slot 0 in the same cycle
        i_replay_stall = 1'b0;
        i_flush        = 1'b1;
        @(negedge clk);
        clear_strobes();
        assert (!o_full) else value_error("o_full", 0, o_full);
        assert (!o_replay_en) else value_error("o_replay_en", 0, o_replay_en);
        check_no_replay(3);
        alloc_load(random_op(1'b0), random_addr());
        @(negedge clk);
        clear_strobes();
        assert (o_alloc_select == one_hot(0))
            else value_error("o_alloc_select", one_hot(0), o_alloc_select);
        finish_test(5, "flush");

        repeat (2) @(negedge clk);
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
lsu_lq_pkg.sv
lq_picker.sv
lq_entry.sv
lsu_lq.sv
tb_clk_gen.sv
tb_lsu_lq.sv
